// File: rtl/eth_pkg.sv
// Shared Ethernet types and constants; the CRC-32 is the reflected form, FCS sent low byte first
package eth_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] crc_t;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hd5;

    localparam int FCS_LEN = 4;

    // Reflected IEEE 802.3 polynomial
    localparam crc_t CRC_POLY    = 32'hedb8_8320;
    localparam crc_t CRC_INIT    = 32'hffff_ffff;
    // Left in the register once a good frame's inverted FCS has passed through
    localparam crc_t CRC_RESIDUE = 32'hdebb_20e3;

    // One byte of CRC-32, LSB first as on the wire
    function automatic crc_t crc_next(input crc_t crc, input byte_t data);
        crc_t c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// File: rtl/byte_stream_if.sv
// Byte stream with valid/ready handshake; tuser on the last byte flags a bad frame
interface byte_stream_if;

    eth_pkg::byte_t tdata;
    logic           tvalid;
    logic           tready;
    logic           tlast;
    logic           tuser;

    modport src (
        output tdata,
        output tvalid,
        input  tready,
        output tlast,
        output tuser
    );

    modport snk (
        input  tdata,
        input  tvalid,
        output tready,
        input  tlast,
        input  tuser
    );

endinterface

// File: rtl/eth_frame_fifo.sv
// Store-and-forward frame FIFO, DEPTH must be a power of two; never stalls input, drops instead
module eth_frame_fifo #(
    parameter int DEPTH = 2048
) (
    input  logic        logic_clk,
    input  logic        logic_rst,
    byte_stream_if.snk  s_axis,
    byte_stream_if.src  m_axis,
    output logic        status_overflow,
    output logic        status_bad_frame,
    output logic        status_good_frame
);

    localparam int AW = $clog2(DEPTH);

    // Each word holds tlast above the data byte
    logic [8:0]  mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] wr_ptr_commit;
    logic [AW:0] commit_rd;     // Read side's copy of the committed pointer
    logic [AW:0] rd_ptr;
    logic        drop_frame;
    logic        in_ready;
    logic        full;
    logic        wr_fire;
    logic        wr_en;
    logic        rd_en;
    logic        out_valid;
    logic [8:0]  out_word;

    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_fire = s_axis.tvalid && s_axis.tready;
    assign wr_en   = wr_fire && !drop_frame && !full;
    assign rd_en   = (rd_ptr != commit_rd) && (!out_valid || m_axis.tready);

    assign s_axis.tready = in_ready;
    assign m_axis.tvalid = out_valid;
    assign m_axis.tdata  = out_word[7:0];
    assign m_axis.tlast  = out_word[8];
    assign m_axis.tuser  = 1'b0;          // Bad frames never reach the output

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            in_ready          <= 1'b0;
            wr_ptr            <= '0;
            wr_ptr_commit     <= '0;
            drop_frame        <= 1'b0;
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;
        end else begin
            in_ready          <= 1'b1;
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;
            if (wr_fire) begin
                if (drop_frame || full) begin
                    // Out of space, so throw away everything since the last commit
                    wr_ptr <= wr_ptr_commit;
                    if (s_axis.tlast) begin
                        drop_frame      <= 1'b0;
                        status_overflow <= 1'b1;
                    end else begin
                        drop_frame <= 1'b1;
                    end
                end else if (s_axis.tlast && s_axis.tuser) begin
                    wr_ptr           <= wr_ptr_commit;
                    status_bad_frame <= 1'b1;
                end else if (s_axis.tlast) begin
                    wr_ptr            <= wr_ptr + 1'b1;
                    wr_ptr_commit     <= wr_ptr + 1'b1;
                    status_good_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {s_axis.tlast, s_axis.tdata};
        end
        if (rd_en) begin
            out_word <= mem[rd_ptr[AW-1:0]];
        end
    end

    // One output register in front of the memory keeps a byte per cycle
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            commit_rd <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            commit_rd <= wr_ptr_commit;
            if (rd_en) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (m_axis.tready) begin
                out_valid <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/eth_mac_tx.sv
// GMII transmit framer; expects whole frames from a frame FIFO, a gap in the input corrupts the frame
module eth_mac_tx #(
    parameter int MIN_FRAME_LEN = 64
) (
    input  logic            logic_clk,
    input  logic            logic_rst,
    byte_stream_if.snk      s_axis,
    output eth_pkg::byte_t  gmii_txd,
    output logic            gmii_tx_en,
    input  logic [7:0]      cfg_tx_ifg
);

    // Data plus pad must reach this before the FCS goes out
    localparam logic [15:0] PAD_LEN = 16'(MIN_FRAME_LEN - eth_pkg::FCS_LEN);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_PAD,
        ST_FCS,
        ST_GAP
    } state_t;

    state_t         state;
    logic [15:0]    byte_cnt;
    eth_pkg::crc_t  crc;

    assign s_axis.tready = (state == ST_DATA);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= ST_IDLE;
            byte_cnt   <= '0;
            crc        <= eth_pkg::CRC_INIT;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    gmii_tx_en <= 1'b0;
                    if (s_axis.tvalid) begin // A committed frame is waiting
                        gmii_tx_en <= 1'b1;
                        gmii_txd   <= eth_pkg::PREAMBLE_BYTE;
                        byte_cnt   <= 16'd1;
                        state      <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    if (byte_cnt < 16'd7) begin
                        gmii_txd <= eth_pkg::PREAMBLE_BYTE;
                        byte_cnt <= byte_cnt + 16'd1;
                    end else begin
                        gmii_txd <= eth_pkg::SFD_BYTE;
                        crc      <= eth_pkg::CRC_INIT;
                        byte_cnt <= '0;
                        state    <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (s_axis.tvalid) begin
                        gmii_txd <= s_axis.tdata;
                        crc      <= eth_pkg::crc_next(crc, s_axis.tdata);
                        byte_cnt <= byte_cnt + 16'd1;
                        if (s_axis.tlast) begin
                            if (byte_cnt + 16'd1 < PAD_LEN) begin
                                state <= ST_PAD;
                            end else begin
                                byte_cnt <= '0;
                                state    <= ST_FCS;
                            end
                        end
                    end
                end
                ST_PAD: begin
                    gmii_txd <= '0;
                    crc      <= eth_pkg::crc_next(crc, 8'h00);
                    byte_cnt <= byte_cnt + 16'd1;
                    if (byte_cnt + 16'd1 >= PAD_LEN) begin
                        byte_cnt <= '0;
                        state    <= ST_FCS;
                    end
                end
                ST_FCS: begin
                    // Inverted CRC, low byte first
                    gmii_txd <= ~crc[8*byte_cnt[1:0] +: 8];
                    byte_cnt <= byte_cnt + 16'd1;
                    if (byte_cnt[1:0] == 2'd3) begin
                        byte_cnt <= '0;
                        state    <= ST_GAP;
                    end
                end
                default: begin
                    gmii_tx_en <= 1'b0;
                    byte_cnt   <= byte_cnt + 16'd1;
                    if (byte_cnt + 16'd1 >= {8'd0, cfg_tx_ifg}) begin
                        state <= ST_IDLE; // IDLE adds one more quiet cycle
                    end
                end
            endcase
        end
    end

endmodule

// File: rtl/eth_mac_rx.sv
// GMII receive deframer; output byte lags its sampling by 5 cycles and the sink must always accept
module eth_mac_rx (
    input  logic            logic_clk,
    input  logic            logic_rst,
    input  eth_pkg::byte_t  gmii_rxd,
    input  logic            gmii_rx_dv,
    byte_stream_if.src      m_axis,
    input  logic [15:0]     cfg_rx_max_pkt_len,
    output logic            error_bad_fcs,
    output logic            error_bad_frame
);

    typedef enum logic [1:0] {
        ST_HUNT,
        ST_DATA,
        ST_SKIP
    } state_t;

    state_t          state;
    eth_pkg::byte_t  dly [4];     // Last four bytes, which may turn out to be the FCS
    logic [2:0]      fill;
    eth_pkg::byte_t  held;
    logic            held_valid;
    eth_pkg::crc_t   crc;
    logic [15:0]     frame_len;
    logic            push;
    logic            bad_fcs;
    logic            too_long;

    assign push     = (state == ST_DATA) && gmii_rx_dv;
    assign bad_fcs  = (crc != eth_pkg::CRC_RESIDUE);
    assign too_long = (frame_len > cfg_rx_max_pkt_len);

    always_ff @(posedge logic_clk) begin
        if (push) begin
            dly[0] <= gmii_rxd;
            for (int i = 1; i < 4; i++) begin
                dly[i] <= dly[i-1];
            end
            if (fill == 3'd4) begin
                held <= dly[3];
            end
        end
        if ((state == ST_DATA) && held_valid) begin
            m_axis.tdata <= held;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state           <= ST_HUNT;
            fill            <= '0;
            held_valid      <= 1'b0;
            crc             <= eth_pkg::CRC_INIT;
            frame_len       <= '0;
            m_axis.tvalid   <= 1'b0;
            m_axis.tlast    <= 1'b0;
            m_axis.tuser    <= 1'b0;
            error_bad_fcs   <= 1'b0;
            error_bad_frame <= 1'b0;
        end else begin
            m_axis.tvalid   <= 1'b0;
            m_axis.tlast    <= 1'b0;
            m_axis.tuser    <= 1'b0;
            error_bad_fcs   <= 1'b0;
            error_bad_frame <= 1'b0;
            case (state)
                ST_HUNT: begin
                    if (gmii_rx_dv && (gmii_rxd == eth_pkg::SFD_BYTE)) begin
                        state      <= ST_DATA;
                        fill       <= '0;
                        held_valid <= 1'b0;
                        crc        <= eth_pkg::CRC_INIT;
                        frame_len  <= '0;
                    end else if (gmii_rx_dv && (gmii_rxd != eth_pkg::PREAMBLE_BYTE)) begin
                        state <= ST_SKIP; // Not a preamble, ignore until the carrier drops
                    end
                end
                ST_DATA: begin
                    if (gmii_rx_dv) begin
                        crc <= eth_pkg::crc_next(crc, gmii_rxd);
                        if (frame_len != 16'hffff) begin
                            frame_len <= frame_len + 16'd1;
                        end
                        if (fill != 3'd4) begin
                            fill <= fill + 3'd1;
                        end else begin
                            held_valid <= 1'b1;
                        end
                        m_axis.tvalid <= held_valid;
                    end else begin
                        state <= ST_HUNT;
                        if (held_valid) begin
                            // The held byte is the last one before the FCS
                            m_axis.tvalid   <= 1'b1;
                            m_axis.tlast    <= 1'b1;
                            m_axis.tuser    <= bad_fcs || too_long;
                            error_bad_fcs   <= bad_fcs;
                            error_bad_frame <= too_long;
                        end else begin
                            error_bad_frame <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (!gmii_rx_dv) begin
                        state <= ST_HUNT;
                    end
                end
            endcase
        end
    end

endmodule

// File: rtl/eth_mac_fifo.sv
// Byte-wide MAC with frame FIFOs, single clock; rx_tready low for long makes the receive FIFO drop
module eth_mac_fifo #(
    parameter int MIN_FRAME_LEN = 64,
    parameter int TX_FIFO_DEPTH = 2048,
    parameter int RX_FIFO_DEPTH = 2048
) (
    input  logic            logic_clk,
    input  logic            logic_rst,
    input  eth_pkg::byte_t  tx_tdata,
    input  logic            tx_tvalid,
    output logic            tx_tready,
    input  logic            tx_tlast,
    input  logic            tx_tuser,
    output eth_pkg::byte_t  rx_tdata,
    output logic            rx_tvalid,
    input  logic            rx_tready,
    output logic            rx_tlast,
    output eth_pkg::byte_t  gmii_txd,
    output logic            gmii_tx_en,
    input  eth_pkg::byte_t  gmii_rxd,
    input  logic            gmii_rx_dv,
    input  logic [7:0]      cfg_tx_ifg,
    input  logic [15:0]     cfg_rx_max_pkt_len,
    output logic            tx_fifo_overflow,
    output logic            tx_fifo_bad_frame,
    output logic            tx_fifo_good_frame,
    output logic            rx_error_bad_fcs,
    output logic            rx_error_bad_frame,
    output logic            rx_fifo_overflow,
    output logic            rx_fifo_bad_frame,
    output logic            rx_fifo_good_frame
);

    byte_stream_if tx_in ();
    byte_stream_if tx_fifo_out ();
    byte_stream_if rx_mac_out ();
    byte_stream_if rx_out ();

    assign tx_in.tdata  = tx_tdata;
    assign tx_in.tvalid = tx_tvalid;
    assign tx_in.tlast  = tx_tlast;
    assign tx_in.tuser  = tx_tuser;    // Marks a frame the transmit FIFO must drop
    assign tx_tready    = tx_in.tready;

    assign rx_tdata     = rx_out.tdata;
    assign rx_tvalid    = rx_out.tvalid;
    assign rx_tlast     = rx_out.tlast;
    assign rx_out.tready = rx_tready;

    eth_frame_fifo #(.DEPTH(TX_FIFO_DEPTH)) tx_fifo (
        .logic_clk(logic_clk), .logic_rst(logic_rst),
        .s_axis(tx_in), .m_axis(tx_fifo_out),
        .status_overflow(tx_fifo_overflow),
        .status_bad_frame(tx_fifo_bad_frame),
        .status_good_frame(tx_fifo_good_frame)
    );

    eth_mac_tx #(.MIN_FRAME_LEN(MIN_FRAME_LEN)) mac_tx (
        .logic_clk(logic_clk), .logic_rst(logic_rst),
        .s_axis(tx_fifo_out), .gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en),
        .cfg_tx_ifg(cfg_tx_ifg)
    );

    eth_mac_rx mac_rx (
        .logic_clk(logic_clk), .logic_rst(logic_rst),
        .gmii_rxd(gmii_rxd), .gmii_rx_dv(gmii_rx_dv), .m_axis(rx_mac_out),
        .cfg_rx_max_pkt_len(cfg_rx_max_pkt_len),
        .error_bad_fcs(rx_error_bad_fcs), .error_bad_frame(rx_error_bad_frame)
    );

    eth_frame_fifo #(.DEPTH(RX_FIFO_DEPTH)) rx_fifo (
        .logic_clk(logic_clk), .logic_rst(logic_rst),
        .s_axis(rx_mac_out), .m_axis(rx_out),
        .status_overflow(rx_fifo_overflow),
        .status_bad_frame(rx_fifo_bad_frame),
        .status_good_frame(rx_fifo_good_frame)
    );

endmodule

// File: tb/eth_mac_fifo_sva.sv
// Protocol checks bound into eth_mac_fifo; they assume rx_tready only changes between clock edges
module eth_mac_fifo_sva (
    input logic           logic_clk,
    input logic           logic_rst,
    input eth_pkg::byte_t rx_tdata,
    input logic           rx_tvalid,
    input logic           rx_tready,
    input logic           gmii_tx_en,
    input logic           tx_fifo_overflow,
    input logic           tx_fifo_bad_frame,
    input logic           tx_fifo_good_frame,
    input logic           rx_fifo_overflow,
    input logic           rx_fifo_bad_frame,
    input logic           rx_fifo_good_frame
);
    timeunit 1ns;
    timeprecision 1ps;

    // A stalled receive byte must wait unchanged for the sink
    rx_hold_stable: assert property (@(posedge logic_clk) disable iff (logic_rst)
        rx_tvalid && !rx_tready |=> rx_tvalid && $stable(rx_tdata))
        else $error("rx_tvalid or rx_tdata changed while rx_tready was low");

    tx_quiet_in_reset: assert property (@(posedge logic_clk) logic_rst |-> !gmii_tx_en)
        else $error("gmii_tx_en high during reset");

    tx_status_onehot: assert property (@(posedge logic_clk) disable iff (logic_rst)
        $onehot0({tx_fifo_overflow, tx_fifo_bad_frame, tx_fifo_good_frame}))
        else $error("two transmit FIFO status pulses in one cycle");

    rx_status_onehot: assert property (@(posedge logic_clk) disable iff (logic_rst)
        $onehot0({rx_fifo_overflow, rx_fifo_bad_frame, rx_fifo_good_frame}))
        else $error("two receive FIFO status pulses in one cycle");

endmodule

// File: tb/eth_mac_fifo_tb.sv
// Testbench for eth_mac_fifo at default parameters; GMII transmit loops back to receive
module eth_mac_fifo_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MIN_FRAME_LEN = 64;
    localparam int RX_FIFO_DEPTH = 2048;
    localparam int TIMEOUT       = 100000;  // Cycles allowed for any single wait
    localparam int CORRUPT_AT    = 10;      // Wire byte index that gets a flipped bit

    logic           logic_clk;
    logic           logic_rst;
    eth_pkg::byte_t tx_tdata;
    logic           tx_tvalid;
    logic           tx_tready;
    logic           tx_tlast;
    logic           tx_tuser;
    eth_pkg::byte_t rx_tdata;
    logic           rx_tvalid;
    logic           rx_tready;
    logic           rx_tlast;
    eth_pkg::byte_t gmii_txd;
    logic           gmii_tx_en;
    eth_pkg::byte_t gmii_rxd;
    logic           gmii_rx_dv;
    logic [7:0]     cfg_tx_ifg;
    logic [15:0]    cfg_rx_max_pkt_len;
    logic           tx_fifo_overflow;
    logic           tx_fifo_bad_frame;
    logic           tx_fifo_good_frame;
    logic           rx_error_bad_fcs;
    logic           rx_error_bad_frame;
    logic           rx_fifo_overflow;
    logic           rx_fifo_bad_frame;
    logic           rx_fifo_good_frame;

    int             seed = 32'h50e0_ae9c;
    string          test_name = "reset";
    eth_pkg::byte_t wire_bytes [$];     // Padded payloads still to appear on gmii_txd
    int             wire_lens [$];
    logic           corrupt_q [$];      // One flag per frame on the wire
    eth_pkg::byte_t pend_bytes [$];     // Frames waiting for their receive FIFO status
    int             pend_lens [$];
    int             pend_kind [$];      // 0 good, 1 bad FCS, 2 too long
    eth_pkg::byte_t rx_bytes [$];       // Bytes the receive stream still owes
    int             rx_lens [$];
    eth_pkg::byte_t wire_buf [$];
    logic           wire_active = 1'b0;
    logic           wire_seen = 1'b0;
    int             wire_gap = 0;
    int             rx_pos = 0;
    int             rx_frames = 0;
    int             overflow_cnt = 0;
    logic           prev_bad_fcs = 1'b0;
    logic           prev_bad_frame = 1'b0;
    logic           overflow_ok = 1'b0;
    logic           rx_hold = 1'b0;

    eth_mac_fifo dut_i (.*);

    bind eth_mac_fifo eth_mac_fifo_sva sva_i (.*);

    initial begin
        logic_clk = 1'b0;
        forever #5 logic_clk = ~logic_clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input eth_pkg::byte_t exp,
                              input eth_pkg::byte_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch in %s (%s): expected %02h, actual %02h",
                               test_name, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch in %s (%s): expected %b, actual %b",
                               test_name, name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            fail_run($sformatf("Mismatch in %s (%s): expected %0d, actual %0d",
                               test_name, name, exp, act));
        end
    endtask

    // Loopback with an optional single-bit error and one cycle of wire delay
    initial begin : gmii_loopback
        int   idx;
        logic flip;
        idx = 0;
        flip = 1'b0;
        gmii_rxd = '0;
        gmii_rx_dv = 1'b0;
        forever begin
            @(posedge logic_clk);
            #1;
            if (gmii_tx_en) begin
                if (idx == 0) begin
                    flip = (corrupt_q.size() != 0) ? corrupt_q.pop_front() : 1'b0;
                end
                gmii_rxd = (flip && idx == CORRUPT_AT) ? gmii_txd ^ 8'h10 : gmii_txd;
                idx++;
            end else begin
                idx = 0;
                gmii_rxd = '0;
            end
            gmii_rx_dv = gmii_tx_en;
        end
    end

    initial begin : rx_ready_drive
        logic ready_roll;
        rx_tready = 1'b0;
        forever begin
            @(negedge logic_clk);
            ready_roll = ({$random(seed)} % 4) != 0;   // Drawn apart from the stimulus draws
            @(posedge logic_clk);
            #1;
            rx_tready = !rx_hold && ready_roll;
        end
    end

    // The wire check uses the model's own copy of the padded payload
    task automatic verify_gmii_frame();
        eth_pkg::crc_t  crc;
        eth_pkg::byte_t b;
        int             n;
        if (wire_lens.size() == 0) begin
            fail_run("frame on gmii_txd that the model does not expect");
        end
        n = wire_lens.pop_front();
        check_count("gmii frame length", n + 12, wire_buf.size());
        for (int i = 0; i < 7; i++) begin
            check_byte("gmii preamble", eth_pkg::PREAMBLE_BYTE, wire_buf[i]);
        end
        check_byte("gmii sfd", eth_pkg::SFD_BYTE, wire_buf[7]);
        crc = eth_pkg::CRC_INIT;
        for (int i = 0; i < n; i++) begin
            b = wire_bytes.pop_front();
            check_byte("gmii data", b, wire_buf[8 + i]);
            crc = eth_pkg::crc_next(crc, b);
        end
        for (int i = 0; i < 4; i++) begin
            check_byte("gmii fcs", ~crc[8*i +: 8], wire_buf[8 + n + i]);
        end
    endtask

    task automatic scan_gmii();
        if (gmii_tx_en) begin
            if (!wire_active) begin
                if (wire_seen && wire_gap < int'(cfg_tx_ifg)) begin
                    fail_run($sformatf("inter-frame gap of %0d cycles is shorter than %0d",
                                       wire_gap, cfg_tx_ifg));
                end
                wire_active = 1'b1;
                wire_buf.delete();
            end
            wire_buf.push_back(gmii_txd);
        end else begin
            if (wire_active) begin
                verify_gmii_frame();
                wire_active = 1'b0;
                wire_seen = 1'b1;
                wire_gap = 0;
            end
            wire_gap++;
        end
    endtask

    // Each frame on the wire ends in exactly one receive FIFO pulse, in order
    task automatic sort_rx_status();
        int kind;
        int n;
        if (tx_fifo_overflow) begin
            fail_run("transmit FIFO overflowed");
        end
        if (rx_fifo_good_frame || rx_fifo_bad_frame || rx_fifo_overflow) begin
            if (pend_kind.size() == 0) begin
                fail_run("receive FIFO status pulse with no frame in flight");
            end
            kind = pend_kind.pop_front();
            n = pend_lens.pop_front();
            if (rx_fifo_good_frame) begin
                check_count("receive frame class", kind, 0);
                check_flag("rx_error_bad_fcs on good frame", 1'b0, prev_bad_fcs);
                check_flag("rx_error_bad_frame on good frame", 1'b0, prev_bad_frame);
                for (int i = 0; i < n; i++) begin
                    rx_bytes.push_back(pend_bytes.pop_front());
                end
                rx_lens.push_back(n);
            end else begin
                if (rx_fifo_bad_frame) begin
                    if (kind == 0) begin
                        fail_run("receive FIFO marked a good frame bad");
                    end
                    check_flag("rx_error_bad_fcs", logic'(kind == 1), prev_bad_fcs);
                    check_flag("rx_error_bad_frame", logic'(kind == 2), prev_bad_frame);
                end else begin
                    if (!overflow_ok) begin
                        fail_run("receive FIFO overflowed while the sink was draining it");
                    end
                    overflow_cnt++;
                end
                for (int i = 0; i < n; i++) begin
                    void'(pend_bytes.pop_front());    // Whole frame is gone
                end
            end
        end
        prev_bad_fcs = rx_error_bad_fcs;
        prev_bad_frame = rx_error_bad_frame;
    endtask

    task automatic compare_rx();
        eth_pkg::byte_t exp;
        if (rx_tvalid && rx_tready) begin
            if (rx_lens.size() == 0) begin
                fail_run("byte on the receive stream that the model does not expect");
            end
            exp = rx_bytes.pop_front();
            check_byte("rx data", exp, rx_tdata);
            check_flag("rx tlast", logic'(rx_pos == rx_lens[0] - 1), rx_tlast);
            if (rx_pos == rx_lens[0] - 1) begin
                void'(rx_lens.pop_front());
                rx_pos = 0;
                rx_frames++;
            end else begin
                rx_pos++;
            end
        end
    endtask

    always @(negedge logic_clk) begin
        if (!logic_rst) begin
            scan_gmii();
            sort_rx_status();
            compare_rx();
        end
    end

    task automatic send_frame(input int len, input logic bad, input logic corrupt);
        eth_pkg::byte_t data [$];
        eth_pkg::byte_t b;
        int             plen;
        int             kind;
        int             t;
        t = 0;
        while (wire_lens.size() >= 4) begin    // Keeps the transmit FIFO far from full
            @(posedge logic_clk);
            #1;
            t++;
            if (t > TIMEOUT) begin
                fail_run("timeout waiting for room in the transmit path");
            end
        end
        for (int i = 0; i < len; i++) begin
            data.push_back(eth_pkg::byte_t'($random(seed)));
        end
        plen = (len < MIN_FRAME_LEN - eth_pkg::FCS_LEN) ? MIN_FRAME_LEN - eth_pkg::FCS_LEN : len;
        if (!bad) begin
            for (int i = 0; i < plen; i++) begin
                b = (i < len) ? data[i] : 8'h00;
                wire_bytes.push_back(b);
                pend_bytes.push_back(b);
            end
            kind = corrupt ? 1 : ((plen + eth_pkg::FCS_LEN > int'(cfg_rx_max_pkt_len)) ? 2 : 0);
            wire_lens.push_back(plen);
            pend_lens.push_back(plen);
            pend_kind.push_back(kind);
            corrupt_q.push_back(corrupt);
        end
        for (int i = 0; i < len; i++) begin
            tx_tvalid = 1'b1;
            tx_tdata = data[i];
            tx_tlast = (i == len - 1);
            tx_tuser = bad && (i == len - 1);
            t = 0;
            @(negedge logic_clk);
            while (!tx_tready) begin
                @(negedge logic_clk);
                t++;
                if (t > TIMEOUT) begin
                    fail_run("timeout waiting for tx_tready");
                end
            end
            @(posedge logic_clk);
            #1;
        end
        tx_tvalid = 1'b0;
        tx_tlast = 1'b0;
        tx_tuser = 1'b0;
        @(negedge logic_clk);
        check_flag("tx_fifo_good_frame", !bad, tx_fifo_good_frame);
        check_flag("tx_fifo_bad_frame", bad, tx_fifo_bad_frame);
        @(posedge logic_clk);
        #1;
    endtask

    task automatic send_random(input int count, input int min_len, input int corrupt_every);
        int len;
        for (int i = 0; i < count; i++) begin
            len = min_len + int'({$random(seed)} % (201 - min_len));
            send_frame(len, 1'b0, corrupt_every != 0 && (i % corrupt_every) == corrupt_every - 1);
        end
    endtask

    // Waits until the model has no frame left in flight, optionally ignoring the receive stream
    task automatic wait_quiet(input string what, input logic need_rx);
        int t;
        t = 0;
        while (pend_kind.size() != 0 || wire_lens.size() != 0 ||
               (need_rx && rx_lens.size() != 0)) begin
            @(posedge logic_clk);
            #1;
            t++;
            if (t > TIMEOUT) begin
                fail_run({"timeout while draining ", what});
            end
        end
    endtask

    task automatic set_rx_hold(input logic value);
        @(negedge logic_clk);
        rx_hold = value;
        @(posedge logic_clk);
        #1;
    endtask

    initial begin : stimulus
        int start;
        tx_tdata = '0;
        tx_tvalid = 1'b0;
        tx_tlast = 1'b0;
        tx_tuser = 1'b0;
        cfg_tx_ifg = 8'd12;
        cfg_rx_max_pkt_len = 16'd1518;
        logic_rst = 1'b1;
        repeat (10) @(posedge logic_clk);
        #1;
        logic_rst = 1'b0;

        test_name = "random frames";
        start = rx_frames;
        send_random(30, 1, 0);
        wait_quiet("random frames", 1'b1);
        check_count("frames out of the random test", 30, rx_frames - start);

        test_name = "transmit bad frame";
        start = rx_frames;
        send_frame(40, 1'b1, 1'b0);    // Dropped by the transmit FIFO
        send_frame(40, 1'b0, 1'b0);
        wait_quiet("transmit bad frame test", 1'b1);
        check_count("frames after a dropped transmit frame", 1, rx_frames - start);

        test_name = "corrupted frames";
        start = rx_frames;
        send_random(12, 1, 3);
        wait_quiet("corrupted frames", 1'b1);
        check_count("frames around corrupted ones", 8, rx_frames - start);

        test_name = "length limit";
        start = rx_frames;
        cfg_rx_max_pkt_len = 16'd100;
        send_random(12, 1, 0);
        send_frame(120, 1'b0, 1'b0);   // 124 bytes with FCS, over the limit
        send_frame(30, 1'b0, 1'b0);    // Padded to 64 bytes, under the limit
        wait_quiet("length limit test", 1'b1);
        cfg_rx_max_pkt_len = 16'd1518;
        if (rx_frames == start) begin
            fail_run("no frame passed the receive length limit");
        end

        // Hold off the sink well past RX_FIFO_DEPTH bytes
        test_name = "receive FIFO overflow";
        overflow_ok = 1'b1;
        set_rx_hold(1'b1);
        send_random(RX_FIFO_DEPTH / 100, 120, 0);
        wait_quiet("frames into a stalled receive FIFO", 1'b0);
        if (overflow_cnt == 0) begin
            fail_run("receive FIFO never overflowed while rx_tready was held low");
        end
        set_rx_hold(1'b0);
        wait_quiet("receive FIFO after release", 1'b1);
        overflow_ok = 1'b0;

        if (wire_bytes.size() == 0 && rx_bytes.size() == 0 && pend_bytes.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run("model still holds bytes at the end of the run");
        end
    end

endmodule

// File: eth_mac_fifo.f
rtl/eth_pkg.sv
rtl/byte_stream_if.sv
rtl/eth_frame_fifo.sv
rtl/eth_mac_tx.sv
rtl/eth_mac_rx.sv
rtl/eth_mac_fifo.sv
tb/eth_mac_fifo_sva.sv
tb/eth_mac_fifo_tb.sv

// File: Makefile
SIM = obj_dir/Veth_mac_fifo_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

$(SIM): eth_mac_fifo.f $(wildcard rtl/*.sv tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module eth_mac_fifo_tb -f eth_mac_fifo.f

clean:
	rm -rf obj_dir
